// ==== verilog/isaPkg.sv ====
package isaPkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Basic types

	typedef logic [15:0] word_t; // Machine word, also the PC.

	localparam int regCount = 8;
	localparam int regAddrWidth = $clog2(regCount);

	typedef logic [regAddrWidth-1:0] regAddr_t;

	localparam regAddr_t linkReg = 3'd7; // JAL writes its return address here.

	// ~~~~~~~~~~~~~~~~~~~~
	// Opcodes in bits 15 to 12

	typedef enum logic [3:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		ADDI = 4'd2,
		LBI  = 4'd3,
		SLBI = 4'd4,
		LD   = 4'd5,
		ST   = 4'd6,
		BEQZ = 4'd7,
		BNEZ = 4'd8,
		J    = 4'd9,
		JAL  = 4'd10,
		JR   = 4'd11
	} opcode_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Field positions

	localparam int opMsb = 15;
	localparam int opLsb = 12;
	localparam int rdMsb = 11; // Also the tested register of BEQZ, BNEZ and JR.
	localparam int rdLsb = 9;
	localparam int rsMsb = 8;
	localparam int rsLsb = 6;
	localparam int rtMsb = 5;
	localparam int rtLsb = 3;

endpackage

// ==== verilog/pipePkg.sv ====
package pipePkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// Control encodings

	typedef enum logic [1:0] {
		IMM_S6  = 2'd0, // Bits 5:0, sign extended.
		IMM_S8  = 2'd1, // Bits 7:0, sign extended.
		IMM_S12 = 2'd2, // Bits 11:0, sign extended.
		IMM_Z8  = 2'd3  // Bits 7:0, zero extended.
	} immSel_t;

	typedef enum logic [2:0] {
		ALU_NOP  = 3'd0,
		ALU_ADD  = 3'd1,
		ALU_PASS = 3'd2 // Pass the immediate through.
	} aluOp_t;

	typedef struct packed {
		immSel_t immSel;
		logic    isBranch;
		logic    branchOnZero; // Taken when the operand is zero.
		logic    isJump;
		logic    jumpRegister; // Target is register plus immediate.
		logic    loadLink;
		logic    dataOut2Sel;  // Set picks rt, clear picks rd.
	} decodeCtrl_t;

	typedef struct packed {
		aluOp_t           aluOp;
		logic             wrRegEn;
		logic             wrMemEn;
		logic             memToReg;
		isaPkg::regAddr_t writeReg;
	} exCtrl_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// Stage bundles

	typedef struct packed {
		logic          valid;
		isaPkg::word_t pc;
		isaPkg::word_t instr;
	} ifId_t;

	typedef struct packed {
		logic          valid;
		exCtrl_t       exCtrl;
		isaPkg::word_t dataOut1;
		isaPkg::word_t dataOut2;
		isaPkg::word_t immediate;
		isaPkg::word_t pcPlus1;
	} idEx_t;

endpackage

// ==== verilog/Control.sv ====
module Control (
	input  isaPkg::word_t        instr,
	input  logic                 valid,
	output pipePkg::decodeCtrl_t decodeCtrl,
	output pipePkg::exCtrl_t     exCtrl
);

	isaPkg::opcode_t opcode;

	assign opcode = isaPkg::opcode_t'(instr[isaPkg::opMsb:isaPkg::opLsb]);

	always_comb begin
		decodeCtrl = '0;
		exCtrl = '0;
		exCtrl.aluOp = pipePkg::ALU_NOP;
		exCtrl.writeReg = instr[isaPkg::rdMsb:isaPkg::rdLsb];
		case (opcode)
			isaPkg::ADD: begin
				exCtrl.aluOp = pipePkg::ALU_ADD;
				exCtrl.wrRegEn = 1'b1;
				decodeCtrl.dataOut2Sel = 1'b1; // Second source is rt.
			end
			isaPkg::ADDI: begin
				decodeCtrl.immSel = pipePkg::IMM_S6;
				exCtrl.aluOp = pipePkg::ALU_ADD;
				exCtrl.wrRegEn = 1'b1;
			end
			isaPkg::LBI: begin
				decodeCtrl.immSel = pipePkg::IMM_S8;
				exCtrl.aluOp = pipePkg::ALU_PASS;
				exCtrl.wrRegEn = 1'b1;
			end
			isaPkg::SLBI: begin
				decodeCtrl.immSel = pipePkg::IMM_Z8;
				exCtrl.aluOp = pipePkg::ALU_PASS;
				exCtrl.wrRegEn = 1'b1;
			end
			isaPkg::LD: begin
				decodeCtrl.immSel = pipePkg::IMM_S6;
				exCtrl.aluOp = pipePkg::ALU_ADD;
				exCtrl.wrRegEn = 1'b1;
				exCtrl.memToReg = 1'b1;
			end
			isaPkg::ST: begin
				decodeCtrl.immSel = pipePkg::IMM_S6;
				exCtrl.aluOp = pipePkg::ALU_ADD;
				exCtrl.wrMemEn = 1'b1; // Store data comes from rd.
			end
			isaPkg::BEQZ, isaPkg::BNEZ: begin
				decodeCtrl.immSel = pipePkg::IMM_S8;
				decodeCtrl.isBranch = 1'b1;
				decodeCtrl.branchOnZero = (opcode == isaPkg::BEQZ);
			end
			isaPkg::J: begin
				decodeCtrl.immSel = pipePkg::IMM_S12;
				decodeCtrl.isJump = 1'b1;
			end
			isaPkg::JAL: begin
				decodeCtrl.immSel = pipePkg::IMM_S12;
				decodeCtrl.isJump = 1'b1;
				decodeCtrl.loadLink = 1'b1; // Return address rides on dataOut2.
				exCtrl.wrRegEn = 1'b1;
				exCtrl.writeReg = isaPkg::linkReg;
			end
			isaPkg::JR: begin
				decodeCtrl.immSel = pipePkg::IMM_S8;
				decodeCtrl.isJump = 1'b1;
				decodeCtrl.jumpRegister = 1'b1;
			end
			default: ; // NOP and unused codes do nothing.
		endcase
		if (!valid) begin
			decodeCtrl = '0;
			exCtrl = '0;
		end
	end

	always_comb begin
		assert final (!(exCtrl.wrRegEn && exCtrl.wrMemEn))
			else $error("Control: register and memory write both enabled.");
	end

endmodule

// ==== verilog/Fetch.sv ====
module Fetch #(
	parameter int imemDepth = 256
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             stall,
	input  logic             redirect,
	input  isaPkg::word_t    target,
	input  logic             imemWrEn,
	input  isaPkg::word_t    imemAddr,
	input  isaPkg::word_t    imemData,
	output pipePkg::ifId_t   fetchOut
);

	localparam int addrWidth = $clog2(imemDepth);

	isaPkg::word_t pc;
	isaPkg::word_t imem [imemDepth];

	// ~~~~~~~~~~~~~~~~~~~~
	// Program counter

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= redirect ? target : pc + 16'd1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Instruction memory

	always_ff @(posedge clk) begin
		if (imemWrEn) begin
			imem[imemAddr[addrWidth-1:0]] <= imemData; // Load port.
		end
	end

	assign fetchOut.valid = 1'b1;
	assign fetchOut.pc = pc;
	assign fetchOut.instr = imem[pc[addrWidth-1:0]]; // Asynchronous read.

	imemLoadInRange: assert property (@(posedge clk) imemWrEn |-> (imemAddr < imemDepth))
		else $error("Fetch: instruction load address %0d out of range.", imemAddr);

endmodule

// ==== verilog/RegFile.sv ====
module RegFile (
	input  logic             clk,
	input  logic             rst,
	input  isaPkg::regAddr_t rdAddr1,
	input  isaPkg::regAddr_t rdAddr2,
	output isaPkg::word_t    rdData1,
	output isaPkg::word_t    rdData2,
	input  logic             wrEn,
	input  isaPkg::regAddr_t wrAddr,
	input  isaPkg::word_t    wrData
);

	isaPkg::word_t regs [isaPkg::regCount];

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int i = 0; i < isaPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Same-cycle write shows up on the read ports.
	always_comb begin
		rdData1 = regs[rdAddr1];
		rdData2 = regs[rdAddr2];
		if (wrEn && (wrAddr == rdAddr1)) begin
			rdData1 = wrData;
		end
		if (wrEn && (wrAddr == rdAddr2)) begin
			rdData2 = wrData;
		end
	end

endmodule

// ==== verilog/Decode.sv ====
module Decode (
	input  pipePkg::ifId_t       ifId,
	input  pipePkg::decodeCtrl_t decodeCtrl,
	input  pipePkg::exCtrl_t     exCtrlIn,
	output isaPkg::regAddr_t     rdAddr1,
	output isaPkg::regAddr_t     rdAddr2,
	input  isaPkg::word_t        rdData1,
	input  isaPkg::word_t        rdData2,
	output logic                 redirect,
	output isaPkg::word_t        target,
	output pipePkg::idEx_t       idEx
);

	isaPkg::regAddr_t rd, rs, rt;
	isaPkg::word_t immediate;
	isaPkg::word_t pcPlus1;
	logic useRd1;
	logic taken;

	assign rd = ifId.instr[isaPkg::rdMsb:isaPkg::rdLsb];
	assign rs = ifId.instr[isaPkg::rsMsb:isaPkg::rsLsb];
	assign rt = ifId.instr[isaPkg::rtMsb:isaPkg::rtLsb];

	// ~~~~~~~~~~~~~~~~~~~~
	// Register reads

	assign useRd1 = decodeCtrl.isBranch || decodeCtrl.jumpRegister || exCtrlIn.wrMemEn;
	assign rdAddr1 = useRd1 ? rd : rs;
	assign rdAddr2 = decodeCtrl.dataOut2Sel ? rt : rd;

	always_comb begin
		case (decodeCtrl.immSel)
			pipePkg::IMM_S6:  immediate = {{10{ifId.instr[5]}}, ifId.instr[5:0]};
			pipePkg::IMM_S8:  immediate = {{8{ifId.instr[7]}}, ifId.instr[7:0]};
			pipePkg::IMM_S12: immediate = {{4{ifId.instr[11]}}, ifId.instr[11:0]};
			default:          immediate = {8'd0, ifId.instr[7:0]};
		endcase
	end

	assign pcPlus1 = ifId.pc + 16'd1;

	// ~~~~~~~~~~~~~~~~~~~~
	// Branch and jump resolution

	assign taken = decodeCtrl.isBranch && ((rdData1 == '0) == decodeCtrl.branchOnZero);
	assign redirect = ifId.valid && (decodeCtrl.isJump || taken);
	assign target = decodeCtrl.jumpRegister ? rdData1 + immediate : pcPlus1 + immediate;

	assign idEx.valid = ifId.valid;
	assign idEx.exCtrl = exCtrlIn;
	assign idEx.dataOut1 = rdData1;
	assign idEx.dataOut2 = decodeCtrl.loadLink ? pcPlus1 : rdData2; // Link value for JAL.
	assign idEx.immediate = immediate;
	assign idEx.pcPlus1 = pcPlus1;

endmodule

// ==== verilog/PipeReg.sv ====
module PipeReg #(
	parameter type payload_t = logic [0:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     hold,
	input  logic     bubble,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			q <= '0;
		end else if (bubble) begin
			q <= '0; // All-zero payload has valid low.
		end else if (!hold) begin
			q <= d;
		end
	end

	holdBubbleExclusive: assert property (@(posedge clk) disable iff (rst) !(hold && bubble))
		else $error("PipeReg: hold and bubble high together.");

endmodule

// ==== verilog/FrontEnd.sv ====
module FrontEnd #(
	parameter int imemDepth = 256
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             stall,
	input  logic             imemWrEn,
	input  isaPkg::word_t    imemAddr,
	input  isaPkg::word_t    imemData,
	input  logic             wbEn,
	input  isaPkg::regAddr_t wbReg,
	input  isaPkg::word_t    wbData,
	output pipePkg::idEx_t   exOut
);

	pipePkg::ifId_t fetchOut, ifIdQ;
	pipePkg::decodeCtrl_t decodeCtrl;
	pipePkg::exCtrl_t exCtrl;
	pipePkg::idEx_t idEx;
	isaPkg::regAddr_t rdAddr1, rdAddr2;
	isaPkg::word_t rdData1, rdData2;
	isaPkg::word_t target;
	logic redirect;

	// ~~~~~~~~~~~~~~~~~~~~
	// Fetch stage

	Fetch #(.imemDepth(imemDepth)) fetchStage (
		.clk(clk), .rst(rst), .stall(stall), .redirect(redirect), .target(target),
		.imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
		.fetchOut(fetchOut)
	);

	PipeReg #(.payload_t(pipePkg::ifId_t)) ifIdReg (
		.clk(clk), .rst(rst), .hold(stall), .bubble(redirect && !stall),
		.d(fetchOut), .q(ifIdQ)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// Decode stage

	Control controlUnit (
		.instr(ifIdQ.instr), .valid(ifIdQ.valid),
		.decodeCtrl(decodeCtrl), .exCtrl(exCtrl)
	);

	RegFile regFile (
		.clk(clk), .rst(rst), .rdAddr1(rdAddr1), .rdAddr2(rdAddr2),
		.rdData1(rdData1), .rdData2(rdData2),
		.wrEn(wbEn), .wrAddr(wbReg), .wrData(wbData) // Writeback from outside.
	);

	Decode decodeStage (
		.ifId(ifIdQ), .decodeCtrl(decodeCtrl), .exCtrlIn(exCtrl),
		.rdAddr1(rdAddr1), .rdAddr2(rdAddr2), .rdData1(rdData1), .rdData2(rdData2),
		.redirect(redirect), .target(target), .idEx(idEx)
	);

	PipeReg #(.payload_t(pipePkg::idEx_t)) idExReg (
		.clk(clk), .rst(rst), .hold(1'b0), .bubble(stall),
		.d(idEx), .q(exOut)
	);

endmodule

// ==== testbench/FrontEndChecker.sv ====
module FrontEndChecker #(
	parameter int imemDepth = 256
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             stall,
	input  logic             imemWrEn,
	input  isaPkg::word_t    imemAddr,
	input  isaPkg::word_t    imemData,
	input  logic             wbEn,
	input  isaPkg::regAddr_t wbReg,
	input  isaPkg::word_t    wbData,
	input  pipePkg::idEx_t   exOut,
	output int               stepCount,
	output int               errorCount
);

	isaPkg::word_t prog [imemDepth]; // Copy taken from the load port.
	isaPkg::word_t regs [isaPkg::regCount];
	isaPkg::word_t pc;
	logic prevTaken;
	logic stallPrev;
	int cycleCount;
	int firstFetch;
	int fillBubbles; // Bubbles not caused by stall.

	initial begin
		for (int i = 0; i < isaPkg::regCount; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		prevTaken = 1'b1; // Reset behaves like a transfer to address 0.
		stallPrev = 1'b1;
		cycleCount = 0;
		firstFetch = -1;
		fillBubbles = 0;
		stepCount = 0;
		errorCount = 0;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Architectural model

	function automatic pipePkg::idEx_t modelStep(input isaPkg::word_t at, input isaPkg::word_t ins,
			output isaPkg::word_t nextPc, output logic taken);
		pipePkg::idEx_t e;
		logic [3:0] op;
		isaPkg::regAddr_t rd, src1, src2;
		isaPkg::word_t imm, d1;
		op = ins[15:12];
		rd = ins[11:9];
		case (op)
			isaPkg::LBI, isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::JR: imm = {{8{ins[7]}}, ins[7:0]};
			isaPkg::SLBI: imm = {8'd0, ins[7:0]};
			isaPkg::J, isaPkg::JAL: imm = {{4{ins[11]}}, ins[11:0]};
			default: imm = {{10{ins[5]}}, ins[5:0]};
		endcase
		src1 = (op == isaPkg::BEQZ || op == isaPkg::BNEZ || op == isaPkg::JR || op == isaPkg::ST)
			? rd : ins[8:6];
		src2 = (op == isaPkg::ADD) ? ins[5:3] : rd;
		d1 = regs[src1];
		e = '0;
		e.valid = 1'b1;
		e.dataOut1 = d1;
		e.dataOut2 = (op == isaPkg::JAL) ? at + 16'd1 : regs[src2];
		e.immediate = imm;
		e.pcPlus1 = at + 16'd1;
		e.exCtrl.writeReg = (op == isaPkg::JAL) ? isaPkg::linkReg : rd;
		e.exCtrl.wrRegEn = (op == isaPkg::ADD || op == isaPkg::ADDI || op == isaPkg::LBI
			|| op == isaPkg::SLBI || op == isaPkg::LD || op == isaPkg::JAL);
		e.exCtrl.wrMemEn = (op == isaPkg::ST);
		e.exCtrl.memToReg = (op == isaPkg::LD);
		if (op == isaPkg::ADD || op == isaPkg::ADDI || op == isaPkg::LD || op == isaPkg::ST) begin
			e.exCtrl.aluOp = pipePkg::ALU_ADD;
		end else if (op == isaPkg::LBI || op == isaPkg::SLBI) begin
			e.exCtrl.aluOp = pipePkg::ALU_PASS;
		end
		taken = (op == isaPkg::J || op == isaPkg::JAL || op == isaPkg::JR
			|| (op == isaPkg::BEQZ && d1 == '0) || (op == isaPkg::BNEZ && d1 != '0));
		nextPc = (op == isaPkg::JR) ? d1 + imm : (taken ? at + 16'd1 + imm : at + 16'd1);
		return e;
	endfunction

	task automatic checkStep();
		pipePkg::idEx_t expected;
		isaPkg::word_t nextPc;
		logic taken;
		int errorsBefore;
		errorsBefore = errorCount;
		expected = modelStep(pc, prog[pc], nextPc, taken);
		if (stallPrev) begin
			$display("step%0d: a valid instruction left decode in a stall cycle", stepCount);
			errorCount++;
		end
		if (exOut !== expected) begin
			$display("CHECK FAILED step%0d bundle expected %h actual %h",
				stepCount, expected, exOut);
			errorCount++;
		end
		if (fillBubbles != (prevTaken ? 1 : 0)) begin
			$display("CHECK FAILED step%0d bubbles expected %0d actual %0d",
				stepCount, prevTaken ? 1 : 0, fillBubbles);
			errorCount++;
		end
		if (stepCount == 0 && cycleCount - firstFetch != 2) begin
			$display("CHECK FAILED step0 latency expected 2 actual %0d", cycleCount - firstFetch);
			errorCount++;
		end
		$display("step%0d pc %h instr %h %s", stepCount, pc, prog[pc],
			(errorCount == errorsBefore) ? "ok" : "error");
		pc = nextPc;
		prevTaken = taken;
		fillBubbles = 0;
		stepCount++;
	endtask

	// exOut seen here was latched one edge earlier, with the stall of that edge.
	always @(posedge clk) begin
		cycleCount++;
		if (imemWrEn) begin
			prog[imemAddr] = imemData;
		end
		if (rst) begin
			stallPrev = 1'b1;
		end else begin
			if (exOut.valid) begin
				checkStep();
			end else if (!stallPrev) begin
				fillBubbles++;
			end
			if (!stall && firstFetch < 0) begin
				firstFetch = cycleCount;
			end
			stallPrev = stall;
			if (wbEn) begin
				regs[wbReg] = wbData; // Mirror of the register file write.
			end
		end
	end

endmodule

// ==== testbench/FrontEnd_tb.sv ====
module FrontEnd_tb;

	localparam int imemDepth = 256;
	localparam int progLen = 64;
	localparam int stepTarget = 300;
	localparam int cycleLimit = 10 + progLen + 4 * stepTarget; // Reset, load, 4 per step.

	logic clk, rst, stall, imemWrEn, wbEn;
	isaPkg::word_t imemAddr, imemData, wbData;
	isaPkg::regAddr_t wbReg;
	pipePkg::idEx_t exOut;
	int seed;
	int r;
	int cycle;
	int stepCount, errorCount;

	FrontEnd #(.imemDepth(imemDepth)) u_dut (
		.clk(clk), .rst(rst), .stall(stall),
		.imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .exOut(exOut)
	);

	FrontEndChecker #(.imemDepth(imemDepth)) frontEndChecker (
		.clk(clk), .rst(rst), .stall(stall),
		.imemWrEn(imemWrEn), .imemAddr(imemAddr), .imemData(imemData),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .exOut(exOut),
		.stepCount(stepCount), .errorCount(errorCount)
	);

	// Random legal instruction; transfers stay inside the program.
	function automatic isaPkg::word_t makeInstr(input int addr);
		isaPkg::word_t w;
		int opNum;
		int t;
		int offset;
		r = $random(seed);
		w = r[15:0];
		opNum = $unsigned($random(seed)) % 12;
		t = $unsigned($random(seed)) % progLen;
		offset = t - addr - 1;
		w[15:12] = (addr == progLen - 1) ? isaPkg::J : opNum[3:0];
		case (w[15:12])
			isaPkg::BEQZ, isaPkg::BNEZ: w[7:0] = offset[7:0];
			isaPkg::J, isaPkg::JAL: w[11:0] = offset[11:0];
			isaPkg::JR: begin
				w[11] = 1'b1; // Base is r4 to r7, which only hold small values.
				w[7:0] = {3'd0, w[4:0]};
			end
			default: ;
		endcase
		return w;
	endfunction

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// Stimulus

	initial begin
		seed = 32'h714b_2a32;
		rst = 1'b1;
		stall = 1'b1; // Held until the whole program is loaded.
		imemWrEn = 1'b0;
		imemAddr = '0;
		imemData = '0;
		wbEn = 1'b0;
		wbReg = '0;
		wbData = '0;
		for (int i = 0; i < progLen; i++) begin
			@(posedge clk);
			imemWrEn <= 1'b1;
			imemAddr <= i[15:0];
			imemData <= makeInstr(i);
			if (i == 9) begin
				rst <= 1'b0;
			end
		end
		@(posedge clk);
		imemWrEn <= 1'b0;
		stall <= 1'b0;
		repeat (4) @(posedge clk); // First instructions run unstalled.
		forever begin
			@(posedge clk);
			r = $random(seed);
			stall <= (r[2:0] == 3'd0);
			wbEn <= r[3];
			wbReg <= r[6:4];
			if (r[8:7] == 2'd0) begin
				wbData <= '0; // Zero often, so branches go both ways.
			end else if (r[6]) begin
				wbData <= {11'd0, r[20:16]};
			end else begin
				wbData <= r[31:16];
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// End of run

	initial begin
		cycle = 0;
		while (stepCount < stepTarget && cycle < cycleLimit) begin
			@(negedge clk);
			cycle++;
		end
		if (stepCount < stepTarget) begin
			$display("Run stopped at the cycle limit of %0d cycles.", cycleLimit);
		end
		$display("Steps checked %0d, failures %0d", stepCount, errorCount);
		if (errorCount == 0 && stepCount >= stepTarget) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== FrontEnd.f ====
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/Control.sv
verilog/Fetch.sv
verilog/RegFile.sv
verilog/Decode.sv
verilog/PipeReg.sv
verilog/FrontEnd.sv
testbench/FrontEndChecker.sv
testbench/FrontEnd_tb.sv
